// ==== Makefile ====
# Verilator build and run of the FIFO testbench

VERILATOR ?= verilator
TOP       ?= fifo_top_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/fifo_top_tb.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_top_tb;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_IDLE, OP_BUS_RD, OP_BUS_CLR} op_e;

    // exp is ignored when use_model is set
    typedef struct packed {
        op_e        op;
        logic [7:0] val;
        logic [7:0] exp;
        logic       use_model;
    } step_t;

    logic                    wr_clk;
    logic                    rd_srst;
    logic                    i_wr;
    logic [`FIFO_DATA_W-1:0] i_wr_data;
    logic                    o_full;
    logic                    i_rd;
    logic [`FIFO_DATA_W-1:0] o_rd_data;
    logic                    o_empty;
    fifo_pkg::wb_req_t       i_wb;
    fifo_pkg::wb_rsp_t       o_wb;

    step_t      steps[$];
    logic [7:0] model_q[$];
    int         vis;
    int         pend;
    int         wr_total;
    int         rd_total;
    logic       m_oflow;
    logic       m_uflow;
    int         seed;
    int         cycle_cnt;
    int         cycle_limit;

    fifo_top dut (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .i_wr      (i_wr),
        .i_wr_data (i_wr_data),
        .o_full    (o_full),
        .i_rd      (i_rd),
        .o_rd_data (o_rd_data),
        .o_empty   (o_empty),
        .i_wb      (i_wb),
        .o_wb      (o_wb)
    );

    always #20 wr_clk = ~wr_clk;

    always @(posedge wr_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the step table did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic add_step(input op_e op, input logic [7:0] val, input logic [7:0] exp,
                            input logic use_model);
        steps.push_back(step_t'{op: op, val: val, exp: exp, use_model: use_model});
    endtask

    task automatic add_steps(input op_e op, input int n);
        repeat (n) add_step(op, 8'h00, 8'h00, 1'b1);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_edge(input logic wr, input logic rd, input logic [7:0] data);
        logic wr_ok;
        logic rd_ok;
        wr_ok   = wr && (model_q.size() < `FIFO_DEPTH);
        rd_ok   = rd && (vis > 0);
        m_oflow = m_oflow || (wr && !wr_ok);
        m_uflow = m_uflow || (rd && !rd_ok);
        if (rd_ok) begin
            void'(model_q.pop_front());
            rd_total++;
        end
        // Accepted data lands one edge after it was taken
        vis  = vis - int'(rd_ok) + pend;
        pend = int'(wr_ok);
        if (wr_ok) begin
            model_q.push_back(data);
            wr_total++;
        end
    endtask

    function automatic logic [7:0] model_reg(input logic [2:0] adr);
        fifo_pkg::fifo_status_u st;
        st.raw     = 8'h00;
        st.f.full  = (model_q.size() >= `FIFO_DEPTH);
        st.f.empty = (vis == 0);
        st.f.oflow = m_oflow;
        st.f.uflow = m_uflow;
        case (adr)
            `FIFO_REG_STATUS:   return st.raw;
            `FIFO_REG_WR_COUNT: return 8'(model_q.size());
            `FIFO_REG_RD_COUNT: return 8'(vis);
            `FIFO_REG_PTRS:     return {4'(rd_total % `FIFO_DEPTH), 4'(wr_total % `FIFO_DEPTH)};
            default:            return 8'h00;
        endcase
    endfunction

    // Wishbone classic access held until ack
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdat);
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = we;
        i_wb.adr = adr;
        i_wb.dat = dat;
        do begin
            @(posedge wr_clk);
            model_edge(1'b0, 1'b0, 8'h00);
            @(negedge wr_clk);
        end while (!o_wb.ack);
        rdat = o_wb.dat;
        i_wb = '0;
    endtask

    // ------------------------------
    // Step execution
    // ------------------------------
    task automatic run_step(input step_t s);
        logic [7:0]             rdat;
        logic [7:0]             want;
        fifo_pkg::fifo_status_u got_st;
        fifo_pkg::fifo_status_u want_st;
        check_eq("o_empty", (vis == 0), o_empty);
        check_eq("o_full", (model_q.size() >= `FIFO_DEPTH), o_full);
        case (s.op)
            OP_WR, OP_RD, OP_IDLE: begin
                i_wr      = (s.op == OP_WR);
                i_rd      = (s.op == OP_RD);
                i_wr_data = 8'($random(seed));
                if (i_rd && vis > 0) begin
                    check_eq("o_rd_data", s.use_model ? model_q[0] : s.exp, o_rd_data);
                end
                @(posedge wr_clk);
                model_edge(i_wr, i_rd, i_wr_data);
                @(negedge wr_clk);
                i_wr = 1'b0;
                i_rd = 1'b0;
            end
            OP_BUS_RD: begin
                // Read data is latched before the state moves on
                want = s.use_model ? model_reg(s.val[2:0]) : s.exp;
                bus_access(1'b0, s.val[2:0], 8'h00, rdat);
                if (s.val[2:0] == `FIFO_REG_STATUS) begin
                    got_st.raw  = rdat;
                    want_st.raw = want;
                    check_eq("status.full", want_st.f.full, got_st.f.full);
                    check_eq("status.empty", want_st.f.empty, got_st.f.empty);
                    check_eq("status.oflow", want_st.f.oflow, got_st.f.oflow);
                    check_eq("status.uflow", want_st.f.uflow, got_st.f.uflow);
                    check_eq("status.rsvd", want_st.f.rsvd, got_st.f.rsvd);
                end else begin
                    check_eq($sformatf("o_wb.dat (reg %0d)", s.val[2:0]), want, rdat);
                end
            end
            OP_BUS_CLR: begin
                bus_access(1'b1, `FIFO_REG_CLEAR, s.val, rdat);
                m_oflow = m_oflow && !s.val[2];
                m_uflow = m_uflow && !s.val[3];
            end
            default: begin
                $display("Step table holds an unknown operation code %0d", s.op);
                fail_run();
            end
        endcase
    endtask

    initial begin
        wr_clk    = 1'b0;
        rd_srst   = 1'b1;
        i_wr      = 1'b0;
        i_wr_data = '0;
        i_rd      = 1'b0;
        i_wb      = '0;
        seed      = 32'h0ca21919;
        vis       = 0;
        pend      = 0;
        wr_total  = 0;
        rd_total  = 0;
        m_oflow   = 1'b0;
        m_uflow   = 1'b0;
        cycle_cnt = 0;

        // After reset
        add_step(OP_BUS_RD, `FIFO_REG_STATUS, 8'h02, 1'b0);
        add_step(OP_BUS_RD, `FIFO_REG_WR_COUNT, 8'h00, 1'b0);
        add_step(OP_BUS_RD, `FIFO_REG_RD_COUNT, 8'h00, 1'b0);
        // Write, let it land, read it back, then a short burst
        add_steps(OP_WR, 1);
        add_steps(OP_IDLE, 1);
        add_steps(OP_RD, 1);
        add_steps(OP_WR, 4);
        add_steps(OP_RD, 4);
        // Fill up, one dropped write, drain
        add_steps(OP_WR, 17);
        add_steps(OP_IDLE, 1);
        add_step(OP_BUS_RD, `FIFO_REG_WR_COUNT, 8'd16, 1'b0);
        add_step(OP_BUS_RD, `FIFO_REG_STATUS, 8'h05, 1'b0);
        add_steps(OP_RD, 16);
        // Underflow, traffic, then clear both flags
        add_steps(OP_RD, 1);
        add_step(OP_BUS_RD, `FIFO_REG_STATUS, 8'h0e, 1'b0);
        add_steps(OP_WR, 2);
        add_steps(OP_IDLE, 1);
        add_steps(OP_RD, 2);
        add_step(OP_BUS_CLR, 8'h0c, 8'h00, 1'b1);
        add_step(OP_BUS_RD, `FIFO_REG_STATUS, 8'h02, 1'b0);
        // Mixed traffic once the pointers have wrapped
        add_steps(OP_WR, 3);
        add_steps(OP_RD, 1);
        add_steps(OP_IDLE, 1);
        add_step(OP_BUS_RD, `FIFO_REG_PTRS, 8'h00, 1'b1);
        add_steps(OP_RD, 1);
        add_steps(OP_WR, 1);
        add_step(OP_BUS_RD, `FIFO_REG_PTRS, 8'h00, 1'b1);
        add_step(OP_BUS_RD, `FIFO_REG_RD_COUNT, 8'h00, 1'b1);
        add_steps(OP_RD, 3);
        add_step(OP_BUS_RD, `FIFO_REG_PTRS, 8'h00, 1'b1);
        add_step(OP_BUS_RD, `FIFO_REG_STATUS, 8'h00, 1'b1);

        cycle_limit = steps.size() * 4 + 50;

        repeat (4) @(posedge wr_clk);
        @(negedge wr_clk);
        rd_srst = 1'b0;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/fifo_pkg.sv
verilog/fifo_ctrl_fsm.sv
verilog/fifo_mem.sv
verilog/fifo_mon_regs.sv
verilog/fifo_top.sv
bench/fifo_top_tb.sv

// ==== verilog/fifo_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_ctrl_fsm (
    input  logic                  wr_clk,
    input  logic                  rd_srst,
    input  logic                  i_wr,
    input  logic                  i_rd,
    output logic                  o_wr_safe,
    output fifo_pkg::fifo_state_t o_state
);

    // ------------------------------
    // Pointers and counts
    // ------------------------------
    logic [`FIFO_CNT_W-1:0] wr_ptr_q;
    logic [`FIFO_CNT_W-1:0] rd_ptr_q;
    logic [`FIFO_CNT_W-1:0] wr_ptr_dly;
    logic [`FIFO_CNT_W-1:0] wr_count;
    logic [`FIFO_CNT_W-1:0] rd_count;
    logic                   full;
    logic                   empty;
    logic                   rd_safe;

    // Write side sees its own pointer, read side only sees landed data
    assign wr_count = wr_ptr_q - rd_ptr_q;
    assign rd_count = wr_ptr_dly - rd_ptr_q;
    assign full     = (wr_count >= `FIFO_DEPTH);
    assign empty    = (rd_count == 0);

    assign o_wr_safe = i_wr && !full;
    assign rd_safe   = i_rd && !empty;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (o_wr_safe) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_safe) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Write pointer delayed to match the memory write pipe
    generate
        if (`FIFO_MEM_WR_LATENCY > 0) begin : g_wr_dly
            logic [`FIFO_MEM_WR_LATENCY-1:0][`FIFO_CNT_W-1:0] dly_q;

            always_ff @(posedge wr_clk) begin
                if (rd_srst) begin
                    dly_q <= '0;
                end else begin
                    dly_q[0] <= wr_ptr_q;
                    for (int i = 1; i < `FIFO_MEM_WR_LATENCY; i++) begin
                        dly_q[i] <= dly_q[i-1];
                    end
                end
            end

            assign wr_ptr_dly = dly_q[`FIFO_MEM_WR_LATENCY-1];
        end else begin : g_no_wr_dly
            assign wr_ptr_dly = wr_ptr_q;
        end
    endgenerate

    // ------------------------------
    // State out
    // ------------------------------
    assign o_state.wr_ptr   = wr_ptr_q[`FIFO_PTR_W-1:0];
    assign o_state.rd_ptr   = rd_ptr_q[`FIFO_PTR_W-1:0];
    assign o_state.wr_count = wr_count;
    assign o_state.rd_count = rd_count;
    assign o_state.full     = full;
    assign o_state.empty    = empty;
    assign o_state.oflow    = i_wr && full;
    assign o_state.uflow    = i_rd && empty;

    a_count_bound : assert property (@(posedge wr_clk) disable iff (rd_srst)
        (wr_count <= `FIFO_DEPTH) && (rd_count <= `FIFO_DEPTH));

    // Delayed pointer lags the live one, so the read side never overtakes it
    a_rd_behind_wr : assert property (@(posedge wr_clk) disable iff (rd_srst)
        rd_count <= wr_count);

endmodule

// ==== verilog/fifo_macros.svh ====
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// FIFO geometry
`define FIFO_DEPTH          16
`define FIFO_DATA_W         8

// Cycles from an accepted write to the array update
`define FIFO_MEM_WR_LATENCY 1

// Derived widths, pointers carry one extra wrap bit internally
`define FIFO_PTR_W          ($clog2(`FIFO_DEPTH))
`define FIFO_CNT_W          ($clog2(`FIFO_DEPTH + 1))

// Monitor register word addresses
`define FIFO_REG_STATUS     3'd0
`define FIFO_REG_WR_COUNT   3'd1
`define FIFO_REG_RD_COUNT   3'd2
`define FIFO_REG_PTRS       3'd3
`define FIFO_REG_CLEAR      3'd4

`endif

// ==== verilog/fifo_mem.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_mem (
    input  logic                    wr_clk,
    input  logic                    i_wr_en,
    input  logic [`FIFO_PTR_W-1:0]  i_wr_addr,
    input  logic [`FIFO_DATA_W-1:0] i_wr_data,
    input  logic [`FIFO_PTR_W-1:0]  i_rd_addr,
    output logic [`FIFO_DATA_W-1:0] o_rd_data
);

    logic [`FIFO_DATA_W-1:0] mem_q [`FIFO_DEPTH];
    logic                    wr_en_d;
    logic [`FIFO_PTR_W-1:0]  wr_addr_d;
    logic [`FIFO_DATA_W-1:0] wr_data_d;

    // Write request pipe, one register stage per latency cycle
    generate
        if (`FIFO_MEM_WR_LATENCY > 0) begin : g_wr_pipe
            logic [`FIFO_MEM_WR_LATENCY-1:0]                   en_q;
            logic [`FIFO_MEM_WR_LATENCY-1:0][`FIFO_PTR_W-1:0]  addr_q;
            logic [`FIFO_MEM_WR_LATENCY-1:0][`FIFO_DATA_W-1:0] data_q;

            for (genvar s = 0; s < `FIFO_MEM_WR_LATENCY; s++) begin : g_stage
                always_ff @(posedge wr_clk) begin
                    if (s == 0) begin
                        en_q[s]   <= i_wr_en;
                        addr_q[s] <= i_wr_addr;
                        data_q[s] <= i_wr_data;
                    end else begin
                        en_q[s]   <= en_q[s-1];
                        addr_q[s] <= addr_q[s-1];
                        data_q[s] <= data_q[s-1];
                    end
                end
            end

            assign wr_en_d   = en_q[`FIFO_MEM_WR_LATENCY-1];
            assign wr_addr_d = addr_q[`FIFO_MEM_WR_LATENCY-1];
            assign wr_data_d = data_q[`FIFO_MEM_WR_LATENCY-1];
        end else begin : g_no_wr_pipe
            assign wr_en_d   = i_wr_en;
            assign wr_addr_d = i_wr_addr;
            assign wr_data_d = i_wr_data;
        end
    endgenerate

    always_ff @(posedge wr_clk) begin
        if (wr_en_d) begin
            mem_q[wr_addr_d] <= wr_data_d;
        end
    end

    // First-word-fall-through read
    assign o_rd_data = mem_q[i_rd_addr];

endmodule

// ==== verilog/fifo_mon_regs.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_mon_regs (
    input  logic                  wr_clk,
    input  logic                  rd_srst,
    input  fifo_pkg::fifo_state_t i_state,
    input  fifo_pkg::wb_req_t     i_wb,
    output fifo_pkg::wb_rsp_t     o_wb
);

    logic                   ack_q;
    logic [7:0]             rd_dat_q;
    logic                   oflow_q;
    logic                   uflow_q;
    logic                   access;
    logic                   clr_wr;
    logic [7:0]             rd_mux;
    fifo_pkg::fifo_status_u status;

    // ------------------------------
    // Bus handshake
    // ------------------------------
    // New access only while ack is low, so ack lasts a single cycle
    assign access = i_wb.cyc && i_wb.stb && !ack_q;
    assign clr_wr = access && i_wb.we && (i_wb.adr == `FIFO_REG_CLEAR);

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            ack_q   <= 1'b0;
            oflow_q <= 1'b0;
            uflow_q <= 1'b0;
        end else begin
            ack_q   <= access;
            // Set beats clear in the same cycle
            oflow_q <= i_state.oflow || (oflow_q && !(clr_wr && i_wb.dat[2]));
            uflow_q <= i_state.uflow || (uflow_q && !(clr_wr && i_wb.dat[3]));
        end
    end

    // ------------------------------
    // Register read
    // ------------------------------
    always_comb begin
        status.f = '{
            rsvd:  4'b0,
            uflow: uflow_q,
            oflow: oflow_q,
            empty: i_state.empty,
            full:  i_state.full
        };
    end

    always_comb begin
        case (i_wb.adr)
            `FIFO_REG_STATUS:   rd_mux = status.raw;
            `FIFO_REG_WR_COUNT: rd_mux = 8'(i_state.wr_count);
            `FIFO_REG_RD_COUNT: rd_mux = 8'(i_state.rd_count);
            // Read pointer in the high nibble, write pointer in the low one
            `FIFO_REG_PTRS:     rd_mux = 8'({i_state.rd_ptr, i_state.wr_ptr});
            default:            rd_mux = 8'h00;
        endcase
    end

    always_ff @(posedge wr_clk) begin
        if (access && !i_wb.we) begin
            rd_dat_q <= rd_mux;
        end
    end

    assign o_wb.ack = ack_q;
    assign o_wb.dat = rd_dat_q;

    // Master keeps the strobe up until the slave has answered
    a_stb_held_to_ack : assert property (@(posedge wr_clk) disable iff (rd_srst)
        $fell(i_wb.stb) |-> ack_q);

endmodule

// ==== verilog/fifo_pkg.sv ====
`include "fifo_macros.svh"

package fifo_pkg;

    // Controller state seen by the monitor
    typedef struct packed {
        logic [`FIFO_PTR_W-1:0] wr_ptr;
        logic [`FIFO_PTR_W-1:0] rd_ptr;
        logic [`FIFO_CNT_W-1:0] wr_count;
        logic [`FIFO_CNT_W-1:0] rd_count;
        logic                   full;
        logic                   empty;
        logic                   oflow;
        logic                   uflow;
    } fifo_state_t;

    // Wishbone classic, 8-bit data, word addressed
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [2:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // Status register layout, bit 0 is full
    typedef struct packed {
        logic [3:0] rsvd;
        logic       uflow;
        logic       oflow;
        logic       empty;
        logic       full;
    } fifo_status_fields_t;

    typedef union packed {
        logic [7:0]          raw;
        fifo_status_fields_t f;
    } fifo_status_u;

endpackage

// ==== verilog/fifo_top.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_top (
    input  logic                    wr_clk,
    input  logic                    rd_srst,

    // Write side
    input  logic                    i_wr,
    input  logic [`FIFO_DATA_W-1:0] i_wr_data,
    output logic                    o_full,

    // Read side, first word fall through
    input  logic                    i_rd,
    output logic [`FIFO_DATA_W-1:0] o_rd_data,
    output logic                    o_empty,

    // Monitor bus
    input  fifo_pkg::wb_req_t       i_wb,
    output fifo_pkg::wb_rsp_t       o_wb
);

    fifo_pkg::fifo_state_t state;
    logic                  wr_safe;

    fifo_ctrl_fsm u_ctrl (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .i_wr      (i_wr),
        .i_rd      (i_rd),
        .o_wr_safe (wr_safe),
        .o_state   (state)
    );

    fifo_mem u_mem (
        .wr_clk    (wr_clk),
        .i_wr_en   (wr_safe),
        .i_wr_addr (state.wr_ptr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (state.rd_ptr),
        .o_rd_data (o_rd_data)
    );

    fifo_mon_regs u_mon (
        .wr_clk  (wr_clk),
        .rd_srst (rd_srst),
        .i_state (state),
        .i_wb    (i_wb),
        .o_wb    (o_wb)
    );

    assign o_full  = state.full;
    assign o_empty = state.empty;

endmodule
